// File: verilog.f
logic/scan_pkg.sv
logic/apb_pkg.sv
logic/apb_scan_regs.sv
logic/scan_sequencer.sv
logic/clk_divider.sv
logic/scan_driver_mux.sv
logic/design_slot.sv
logic/scan_subsystem.sv
sim/scan_tb.sv

// File: Makefile
TOP = scan_tb

all: run

run:
	verilator --binary --timing -j 0 --top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

// File: sim/scan_tb.sv
`timescale 1ns/100ps

module scan_tb import scan_pkg::*, apb_pkg::*; ;

    localparam int N              = 4;
    localparam int REFRESH_CYCLES = 32 * N + 2;   // START + LOAD + LATCH + READ
    localparam int NUM_ROWS       = 6;
    localparam int NUM_RANDOM     = 4;
    localparam int WATCHDOG_CYCLES = ((NUM_ROWS + NUM_RANDOM) * 3 + 20) * REFRESH_CYCLES;

    typedef struct packed {
        logic [8:0] slot;
        io_byte_t   in_byte;
        io_byte_t   expect_byte;  // rotate left then xor slot key
    } row_t;

    logic      clk;
    logic      reset;
    apb_req_t  apb_req;
    apb_rsp_t  apb_rsp;
    scan_bus_t ext_bus;
    logic      ext_data_out;
    logic      ready;
    logic      slow_clk;
    row_t      rows [NUM_ROWS];

    scan_subsystem #(
        .NUM_DESIGNS   (N),
        .DIV_MIN_WIDTH (2)
    ) scan_subsystem_i (
        .clk          (clk),
        .reset        (reset),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .ext_bus      (ext_bus),
        .ext_data_out (ext_data_out),
        .ready        (ready),
        .slow_clk     (slow_clk)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    // keys are 5a 8d c0 f3 for slots 0 to 3
    function automatic io_byte_t slot_result(input int slot, input io_byte_t in_byte);
        logic [7:0] key;
        key = SLOT_KEY_BASE + 8'(slot) * SLOT_KEY_STEP;  // 8 bit wrap
        return {in_byte[NUM_IOS-2:0], in_byte[NUM_IOS-1]} ^ key;
    endfunction

    task automatic stop_on_mismatch(input string msg);
        $display("FAIL %0t ns: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1, "value check failed");
    endtask

    task automatic check_byte(input io_byte_t got, input io_byte_t exp, input string what);
        if (got !== exp)
            stop_on_mismatch($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
            stop_on_mismatch($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_on_mismatch($sformatf("%s got %b expected %b", what, got, exp));
    endtask

    // setup then access cycle with the response sampled mid access cycle
    task automatic apb_access(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic slverr);
        @(posedge clk);
        apb_req <= '{1'b1, 1'b0, write, addr, wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        check_bit(apb_rsp.pready, 1'b1, "pready in access cycle");  // zero wait slave
        @(posedge clk);  // write lands on this edge
        apb_req <= '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] d;
        logic        err;
        apb_access(1'b1, addr, data, d, err);
        check_bit(err, 1'b0, $sformatf("pslverr on write to %h", addr));
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, 32'h0, data, err);
        check_bit(err, 1'b0, $sformatf("pslverr on read of %h", addr));
    endtask

    task automatic check_rw(input logic [7:0] addr, input logic [31:0] data,
                            input logic [31:0] mask);
        logic [31:0] d;
        apb_write(addr, data);
        apb_read(addr, d);
        check_word(d, data & mask, $sformatf("readback of %h", addr));
    endtask

    // result shows up two refreshes after the input write, counted on the DUT refresh counter
    task automatic run_refresh_row(input logic [8:0] slot, input io_byte_t in_byte,
                                   input io_byte_t exp);
        logic [31:0] base;
        logic [31:0] cnt;
        logic [31:0] d;
        apb_write(ADDR_SELECT, 32'(slot));
        apb_write(ADDR_INPUTS, 32'(in_byte));
        apb_read(ADDR_REFRESH, base);
        do begin
            apb_read(ADDR_REFRESH, cnt);
        end while (cnt[15:0] != base[15:0] + 16'd2);
        apb_read(ADDR_OUTPUTS, d);
        check_byte(d[7:0], exp, $sformatf("slot %0d input %h", slot, in_byte));
    endtask

    task automatic wait_ready(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ready);
    endtask

    // one scan clock period on the pins with the low half first
    task automatic ext_clock(input logic data, input logic strobe, output logic sampled);
        @(posedge clk);
        ext_bus <= '{scan_clk: 1'b0, data: data, select: 1'b0, latch_en: 1'b0};
        @(negedge clk);
        sampled = ext_data_out;  // previous rise has shifted by now
        @(posedge clk);
        ext_bus <= '{scan_clk: 1'b1, data: data, select: strobe, latch_en: strobe};
    endtask

    task automatic external_drive();
        io_byte_t bytes [N];
        io_byte_t got;
        logic     b;
        apb_write(ADDR_CTRL, 32'(DRV_EXTERNAL));
        for (int i = 0; i < N; i++)
            bytes[i] = 8'($urandom);
        for (int s = N - 1; s >= 0; s--)  // first bits end in the last slot
            for (int k = NUM_IOS - 1; k >= 0; k--)
                ext_clock(bytes[s][k], 1'b0, b);
        ext_clock(1'b0, 1'b1, b);  // latch and capture
        for (int j = 0; j < N; j++) begin
            got = '0;
            for (int k = 0; k < NUM_IOS; k++) begin
                ext_clock(1'b0, 1'b0, b);
                got = {got[NUM_IOS-2:0], b};  // MSB first
            end
            check_byte(got, slot_result(N - 1 - j, bytes[N - 1 - j]),
                       $sformatf("external readout of slot %0d", N - 1 - j));
        end
        @(posedge clk);
        ext_bus <= '0;
    endtask

    // first rise is skipped since the tap switch may fake one
    task automatic measure_slow_period(output int cycles);
        logic prev;
        int   rises;
        rises  = 0;
        cycles = 0;
        @(negedge clk);
        prev = slow_clk;
        while (rises < 3) begin
            @(negedge clk);
            if (rises >= 2)
                cycles++;
            if (slow_clk && !prev)
                rises++;
            prev = slow_clk;
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] d;
        logic [31:0] c0;
        logic        err;
        int          n;
        void'($urandom(32'h05205d92));
        apb_req <= '0;
        ext_bus <= '0;
        reset   <= 1'b1;
        rows = '{'{9'd0, 8'h00, 8'h5a}, '{9'd1, 8'h81, 8'h8e}, '{9'd2, 8'h3c, 8'hb8},
                 '{9'd3, 8'hff, 8'h0c}, '{9'd3, 8'h12, 8'hd7}, '{9'd0, 8'ha5, 8'h11}};
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        check_rw(ADDR_CTRL, 32'hffff_fffe, 32'h3);  // code 2 acts as external
        check_rw(ADDR_CTRL, 32'h0, 32'h3);
        check_rw(ADDR_SELECT, 32'hdead_beef, 32'h1ff);
        check_rw(ADDR_INPUTS, 32'h1234_56a5, 32'hff);
        check_rw(ADDR_DIVIDER, 32'hffff_fff5, 32'h7);
        apb_write(ADDR_OUTPUTS, 32'hffff_ffff);     // read only
        apb_read(ADDR_OUTPUTS, d);
        check_word(d, 32'h0, "outputs after write");
        apb_write(ADDR_REFRESH, 32'hffff_ffff);
        apb_read(ADDR_REFRESH, d);
        check_word(d, 32'h0, "refresh count after write");
        apb_access(1'b0, 8'h18, 32'h0, d, err);
        check_bit(err, 1'b1, "pslverr on unmapped read");
        apb_access(1'b1, 8'h40, 32'h1, d, err);
        check_bit(err, 1'b1, "pslverr on unmapped write");

        apb_write(ADDR_CTRL, 32'(DRV_INTERNAL));
        for (int r = 0; r < NUM_ROWS; r++)
            run_refresh_row(rows[r].slot, rows[r].in_byte, rows[r].expect_byte);
        for (int r = 0; r < NUM_RANDOM; r++) begin
            rows[0].slot    = 9'($urandom % N);
            rows[0].in_byte = 8'($urandom);
            run_refresh_row(rows[0].slot, rows[0].in_byte,
                            slot_result(int'(rows[0].slot), rows[0].in_byte));
        end

        wait_ready(n);
        repeat (3) begin
            wait_ready(n);
            check_word(n, REFRESH_CYCLES, "ready spacing");
        end
        apb_read(ADDR_REFRESH, c0);
        wait_ready(n);
        apb_read(ADDR_REFRESH, d);
        check_word(d, c0 + 32'd1, "refresh count per ready");

        apb_write(ADDR_CTRL, 32'(DRV_EXTERNAL));
        apb_read(ADDR_REFRESH, c0);
        repeat (2 * REFRESH_CYCLES) begin
            @(negedge clk);
            check_bit(ready, 1'b0, "ready with external drive");
        end
        apb_read(ADDR_REFRESH, d);
        check_word(d, c0, "refresh count with external drive");

        external_drive();

        for (int v = 0; v < 4; v++) begin
            apb_write(ADDR_DIVIDER, 32'(v));
            measure_slow_period(n);
            check_word(n, 32'd1 << (3 + v), $sformatf("slow_clk period at divider %0d", v));
        end

        $display("** PASS **");
        $finish;
    end

endmodule

// File: logic/scan_subsystem.sv
`timescale 1ns/100ps

module scan_subsystem import scan_pkg::*, apb_pkg::*; #(
    parameter int NUM_DESIGNS   = 4,
    parameter int DIV_MIN_WIDTH = 13
) (
    input  logic      clk,
    input  logic      reset,
    input  apb_req_t  apb_req,
    output apb_rsp_t  apb_rsp,
    input  scan_bus_t ext_bus,       // external driver pins
    output logic      ext_data_out,
    output logic      ready,         // high once per internal refresh
    output logic      slow_clk
);

    driver_sel_t            driver_sel;
    logic [8:0]             active_select;
    io_byte_t               inputs;
    io_byte_t               outputs;
    logic [2:0]             divider;
    logic                   divider_load;
    logic                   refresh_done;
    scan_bus_t              int_bus;
    scan_bus_t              chain_bus;
    logic                   chain_in;
    logic [NUM_DESIGNS:0]   chain_link;  // link n feeds slot n

    apb_scan_regs apb_scan_regs_i (
        .clk           (clk),
        .reset         (reset),
        .apb_req       (apb_req),
        .apb_rsp       (apb_rsp),
        .refresh_done  (refresh_done),
        .outputs       (outputs),
        .driver_sel    (driver_sel),
        .active_select (active_select),
        .inputs        (inputs),
        .divider       (divider),
        .divider_load  (divider_load)
    );

    scan_sequencer #(
        .NUM_DESIGNS (NUM_DESIGNS)
    ) scan_sequencer_i (
        .clk           (clk),
        .reset         (reset),
        .driver_sel    (driver_sel),
        .active_select (active_select),
        .inputs        (inputs),
        .chain_in      (chain_in),
        .int_bus       (int_bus),
        .outputs       (outputs),
        .ready         (ready),
        .refresh_done  (refresh_done)
    );

    clk_divider #(
        .DIV_MIN_WIDTH (DIV_MIN_WIDTH)
    ) clk_divider_i (
        .clk          (clk),
        .reset        (reset),
        .divider      (divider),
        .divider_load (divider_load),
        .slow_clk     (slow_clk)
    );

    scan_driver_mux scan_driver_mux_i (
        .driver_sel   (driver_sel),
        .int_bus      (int_bus),
        .ext_bus      (ext_bus),
        .chain_out    (chain_link[NUM_DESIGNS]),
        .chain_bus    (chain_bus),
        .chain_in     (chain_in),
        .ext_data_out (ext_data_out)
    );

    assign chain_link[0] = chain_bus.data;  // serial bit enters at slot 0

    for (genvar i = 0; i < NUM_DESIGNS; i++) begin : g_slot
        design_slot #(
            .SLOT_INDEX (i)
        ) design_slot_i (
            .clk       (clk),
            .reset     (reset),
            .chain_bus (chain_bus),
            .data_in   (chain_link[i]),
            .data_out  (chain_link[i+1])
        );
    end

endmodule

// File: logic/design_slot.sv
`timescale 1ns/100ps

module design_slot import scan_pkg::*; #(
    parameter int SLOT_INDEX = 0
) (
    input  logic      clk,
    input  logic      reset,
    input  scan_bus_t chain_bus,
    input  logic      data_in,   // from the previous slot or the driver
    output logic      data_out   // to the next slot
);

    localparam logic [7:0] SLOT_KEY = 8'(SLOT_KEY_BASE + SLOT_INDEX * SLOT_KEY_STEP);

    logic     scan_clk_q;
    logic     scan_rise;
    io_byte_t shift_q;
    io_byte_t latch_q;
    io_byte_t latch_d;
    io_byte_t user_out;

    assign scan_rise = chain_bus.scan_clk && !scan_clk_q;

    // latch is transparent while latch_en is high, so a capture on the
    // latching edge already sees the new byte
    assign latch_d = chain_bus.latch_en ? shift_q : latch_q;

    // user design, rotate left by one then xor the slot key
    assign user_out = {latch_d[NUM_IOS-2:0], latch_d[NUM_IOS-1]} ^ SLOT_KEY;

    assign data_out = shift_q[NUM_IOS-1];  // MSB leaves first

    always_ff @(posedge clk) begin
        if (reset)
            scan_clk_q <= 1'b0;
        else
            scan_clk_q <= chain_bus.scan_clk;
    end

    always_ff @(posedge clk) begin
        latch_q <= latch_d;
        if (scan_rise) begin
            if (chain_bus.select)
                shift_q <= user_out;  // capture
            else
                shift_q <= {shift_q[NUM_IOS-2:0], data_in};
        end
    end

endmodule

// File: logic/scan_driver_mux.sv
`timescale 1ns/100ps

module scan_driver_mux import scan_pkg::*; (
    input  driver_sel_t driver_sel,
    input  scan_bus_t   int_bus,       // from the sequencer
    input  scan_bus_t   ext_bus,       // from the pins
    input  logic        chain_out,     // last slot serial out
    output scan_bus_t   chain_bus,     // to every slot
    output logic        chain_in,      // back to the sequencer
    output logic        ext_data_out   // back to the pins
);

    logic use_int;

    // unnamed select codes fall back to the pins
    assign use_int = (driver_sel == DRV_INTERNAL);

    always_comb begin
        if (use_int)
            chain_bus = int_bus;
        else
            chain_bus = ext_bus;
    end

    // return bit goes to both drivers, the idle one ignores it
    assign chain_in     = chain_out;
    assign ext_data_out = chain_out;

endmodule

// File: logic/clk_divider.sv
`timescale 1ns/100ps

module clk_divider #(
    parameter int DIV_MIN_WIDTH = 13  // fastest period is 2^(DIV_MIN_WIDTH+1)
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [2:0] divider,
    input  logic       divider_load,
    output logic       slow_clk
);

    logic [DIV_MIN_WIDTH+7:0] counter;  // top tap is DIV_MIN_WIDTH + 7
    logic [2:0]               setting;

    // each setting step halves the frequency
    assign slow_clk = counter[DIV_MIN_WIDTH + int'(setting)];

    always_ff @(posedge clk) begin
        if (reset) begin
            counter <= '0;
            setting <= '0;
        end else begin
            counter <= counter + 1'b1;  // free running
            if (divider_load)
                setting <= divider;
        end
    end

endmodule

// File: logic/scan_sequencer.sv
`timescale 1ns/100ps

module scan_sequencer import scan_pkg::*; #(
    parameter int NUM_DESIGNS = 4
) (
    input  logic        clk,
    input  logic        reset,
    input  driver_sel_t driver_sel,
    input  logic [8:0]  active_select,
    input  io_byte_t    inputs,
    input  logic        chain_in,      // serial return from the last slot
    output scan_bus_t   int_bus,
    output io_byte_t    outputs,       // result of the previous refresh
    output logic        ready,
    output logic        refresh_done
);

    localparam int              BIT_W       = $clog2(NUM_IOS);
    localparam logic [BIT_W-1:0] LAST_BIT   = BIT_W'(NUM_IOS - 1);
    localparam logic [8:0]      LAST_DESIGN = 9'(NUM_DESIGNS - 1);

    typedef enum logic [1:0] {
        START,  // sample inputs, publish outputs
        LOAD,   // shift 8N bits in
        LATCH,  // latch and capture on one scan clock edge
        READ    // shift 8N bits out
    } state_t;

    state_t           state;
    logic             run;         // internal driver selected
    logic             scan_clk_r;
    logic [8:0]       design_cnt;  // chain position, 0 is the last slot
    logic [BIT_W-1:0] bit_cnt;     // bit in the current byte, MSB first
    logic [8:0]       sel_rev;     // chain position of the active slot
    logic             in_window;
    logic             step;        // counters advance this cycle
    logic             last_bit;
    io_byte_t         inputs_r;
    io_byte_t         read_buf;

    assign run       = (driver_sel == DRV_INTERNAL);
    assign sel_rev   = LAST_DESIGN - active_select;  // out of range select never matches
    assign in_window = (design_cnt == sel_rev);
    assign last_bit  = (bit_cnt == LAST_BIT) && (design_cnt == LAST_DESIGN);

    // LOAD has data valid on the high half, counters move after the low half
    // READ samples on the high half and moves on right after it
    assign step = (state == LOAD) ? !scan_clk_r : scan_clk_r;

    assign ready        = run && (state == START);
    assign refresh_done = run && (state == READ) && step && last_bit;  // last READ cycle

    // bus follows the held state when another driver owns the chain
    always_comb begin
        int_bus.scan_clk = scan_clk_r;
        int_bus.data     = ((state == LOAD) && in_window) ? inputs_r[LAST_BIT - bit_cnt] : 1'b0;
        int_bus.select   = (state == LATCH);
        int_bus.latch_en = (state == LATCH);
    end

    always_ff @(posedge clk) begin
        if (run && state == START)
            inputs_r <= inputs;  // one byte per refresh
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= START;
            scan_clk_r <= 1'b0;
            design_cnt <= '0;
            bit_cnt    <= '0;
            outputs    <= '0;
            read_buf   <= '0;
        end else if (run) begin
            case (state)
                START: begin
                    outputs    <= read_buf;
                    scan_clk_r <= 1'b1;  // first LOAD cycle is a high half
                    state      <= LOAD;
                end
                LOAD, READ: begin
                    scan_clk_r <= !scan_clk_r;
                    // slots shift at the end of this high half, so take the bit now
                    if (state == READ && scan_clk_r && in_window)
                        read_buf[LAST_BIT - bit_cnt] <= chain_in;
                    if (step) begin
                        bit_cnt <= bit_cnt + 1'b1;  // wraps after the MSB..LSB run
                        if (bit_cnt == LAST_BIT) begin
                            design_cnt <= design_cnt + 1'b1;
                            if (design_cnt == LAST_DESIGN) begin
                                design_cnt <= '0;
                                state      <= (state == LOAD) ? LATCH : START;
                            end
                        end
                    end
                end
                LATCH: begin
                    // scan clock is high here after a low LOAD half
                    scan_clk_r <= 1'b0;
                    state      <= READ;
                end
                default: state <= START;
            endcase
        end
    end

endmodule

// File: logic/apb_scan_regs.sv
`timescale 1ns/100ps

module apb_scan_regs import scan_pkg::*, apb_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  apb_req_t    apb_req,
    output apb_rsp_t    apb_rsp,
    input  logic        refresh_done,   // one pulse per finished refresh
    input  io_byte_t    outputs,        // held by the sequencer
    output driver_sel_t driver_sel,
    output logic [8:0]  active_select,
    output io_byte_t    inputs,
    output logic [2:0]  divider,
    output logic        divider_load
);

    logic        access;       // apb access phase
    logic        wr;
    logic        hit;          // address is in the map
    logic [31:0] rdata;
    logic [15:0] refresh_cnt;

    assign access = apb_req.psel && apb_req.penable;
    assign wr     = access && apb_req.pwrite;

    // read mux, also decides if the address exists
    always_comb begin
        rdata = '0;
        hit   = 1'b1;
        case (apb_req.paddr)
            ADDR_CTRL:    rdata[1:0]         = driver_sel;
            ADDR_SELECT:  rdata[8:0]         = active_select;
            ADDR_INPUTS:  rdata[NUM_IOS-1:0] = inputs;
            ADDR_DIVIDER: rdata[2:0]         = divider;
            ADDR_OUTPUTS: rdata[NUM_IOS-1:0] = outputs;
            ADDR_REFRESH: rdata[15:0]        = refresh_cnt;
            default:      hit                = 1'b0;
        endcase
    end

    always_comb begin
        apb_rsp.prdata  = rdata;
        apb_rsp.pready  = 1'b1;            // zero wait
        apb_rsp.pslverr = access && !hit;  // only flagged in the access cycle
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            driver_sel    <= DRV_EXTERNAL;
            active_select <= '0;
            inputs        <= '0;
            divider       <= '0;
            divider_load  <= 1'b0;
            refresh_cnt   <= '0;
        end else begin
            divider_load <= 1'b0;  // single cycle strobe
            if (wr) begin
                // read only and unmapped addresses fall into default
                case (apb_req.paddr)
                    ADDR_CTRL:    driver_sel    <= driver_sel_t'(apb_req.pwdata[1:0]);
                    ADDR_SELECT:  active_select <= apb_req.pwdata[8:0];
                    ADDR_INPUTS:  inputs        <= apb_req.pwdata[NUM_IOS-1:0];
                    ADDR_DIVIDER: begin
                        divider      <= apb_req.pwdata[2:0];
                        divider_load <= 1'b1;  // divider is stable when this is seen
                    end
                    default: ;
                endcase
            end
            if (refresh_done)
                refresh_cnt <= refresh_cnt + 1'b1;  // wraps at 16 bits
        end
    end

endmodule

// File: logic/apb_pkg.sv
package apb_pkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;   // byte address, word aligned map
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;   // no wait states
        logic        pslverr;  // unmapped address
    } apb_rsp_t;

    // register map
    localparam logic [7:0] ADDR_CTRL    = 8'h00;  // driver select
    localparam logic [7:0] ADDR_SELECT  = 8'h04;  // active slot
    localparam logic [7:0] ADDR_INPUTS  = 8'h08;  // byte for the active slot
    localparam logic [7:0] ADDR_DIVIDER = 8'h0c;  // slow clock setting
    localparam logic [7:0] ADDR_OUTPUTS = 8'h10;  // read only, last result
    localparam logic [7:0] ADDR_REFRESH = 8'h14;  // read only, refresh count

endpackage

// File: logic/scan_pkg.sv
package scan_pkg;

    // bits per slot, both directions
    localparam int NUM_IOS = 8;

    typedef logic [NUM_IOS-1:0] io_byte_t;  // one slot's input or output byte

    // who drives the slot chain
    // codes 2 and 3 are not named and act as external
    typedef enum logic [1:0] {
        DRV_EXTERNAL = 2'd0,  // pins at the top level
        DRV_INTERNAL = 2'd1   // on-chip refresh sequencer
    } driver_sel_t;

    // driver to chain, same bundle for internal and external
    typedef struct packed {
        logic scan_clk;  // level, slots look for low to high on clk
        logic data;      // serial bit into slot 0
        logic select;    // capture user outputs instead of shifting
        logic latch_en;  // copy shift register into the input latch
    } scan_bus_t;

    // per slot key, key(n) = base + n * step, wraps at 8 bits
    localparam logic [7:0] SLOT_KEY_BASE = 8'h5a;
    localparam logic [7:0] SLOT_KEY_STEP = 8'h33;

endpackage
